// File: source/ahb_lite_pkg.sv
// AHB-Lite bus encodings
// Transfer types, the word size code and the response values used by
// the slave front end and by the testbench master

`default_nettype none

package ahb_lite_pkg;

  // HTRANS encoding
  typedef enum logic [1:0] {
    htrans_idle   = 2'b00,
    htrans_busy   = 2'b01,
    htrans_nonseq = 2'b10,
    htrans_seq    = 2'b11
  } htrans_e;

  // HSIZE code of a full 32-bit word
  localparam logic [2:0] hsize_word = 3'b010;

  // HRESP values
  localparam logic hresp_okay  = 1'b0;
  localparam logic hresp_error = 1'b1;

endpackage

`default_nettype wire

// File: source/timer_pkg.sv
// Timer peripheral definitions
// Channel count, bus widths and the register map of the timer

`default_nettype none

package timer_pkg;

  // Number of compare channels
  localparam int timers = 3;

  // Bus widths
  localparam int haddr_size = 16;
  localparam int hdata_size = 32;

  // Word index of a register
  localparam int reg_idx_size = 5;
  typedef logic [reg_idx_size-1:0] reg_idx_t;

  ////////////////////////////////////////////////////////////
  // Register map, byte offsets
  ////////////////////////////////////////////////////////////
  localparam logic [haddr_size-1:0] reg_ctrl         = 16'h0000;
  localparam logic [haddr_size-1:0] reg_prescale     = 16'h0004;
  localparam logic [haddr_size-1:0] reg_mtime        = 16'h0008;
  localparam logic [haddr_size-1:0] reg_ien          = 16'h000C;
  localparam logic [haddr_size-1:0] reg_ipend        = 16'h0010;
  localparam logic [haddr_size-1:0] reg_timecmp_base = 16'h0020;

  // Compare registers come out of reset at the far end of time
  localparam logic [hdata_size-1:0] cmp_reset = '1;

  // Byte address to word index, the two low bits are dropped
  function automatic reg_idx_t reg_index(input logic [haddr_size-1:0] addr);
    return reg_idx_t'(addr >> 2);
  endfunction

endpackage

`default_nettype wire

// File: source/timer_reg_if.sv
// Timer register access interface
// Carries one decoded register access per data phase from the AHB
// front end to the register bank, read data comes back combinationally

`timescale 1ns/1ps
`default_nettype none

interface timer_reg_if
  import timer_pkg::*;
();

  // Access strobe, high for one data phase
  logic                  valid;
  logic                  write;
  // Word index of the target register
  reg_idx_t              idx;
  logic [hdata_size-1:0] wdata;
  // Read data for idx, no register stage
  logic [hdata_size-1:0] rdata;

  // Bus front end side
  modport bus (output valid, output write, output idx, output wdata, input rdata);

  // Register bank side
  modport regs (input valid, input write, input idx, input wdata, output rdata);

endinterface

`default_nettype wire

// File: source/timer_ahb_slave.sv
// AHB-Lite slave front end of the timer
// Captures the address phase, accepts word accesses with no wait state
// and answers any other size with the two-cycle ERROR response

`timescale 1ns/1ps
`default_nettype none

module timer_ahb_slave
  import ahb_lite_pkg::*;
  import timer_pkg::*;
(
  input  wire logic                  hclk,
  input  wire logic                  rst_n,
  input  wire logic                  hsel,
  input  wire logic [haddr_size-1:0] haddr,
  input  wire logic [hdata_size-1:0] hwdata,
  input  wire logic                  hwrite,
  input  wire logic [2:0]            hsize,
  input  wire logic [1:0]            htrans,
  input  wire logic                  hready,
  output logic      [hdata_size-1:0] hrdata,
  output logic                       hreadyout,
  output logic                       hresp,
  timer_reg_if.bus                   reg_bus
);

  // Response state of the data phase
  typedef enum logic [1:0] {
    st_okay,
    st_err_wait,
    st_err_last
  } state_e;

  state_e   state;
  logic     accept;
  logic     size_ok;
  logic     dp_valid;
  logic     dp_write;
  reg_idx_t dp_idx;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  // NONSEQ or SEQ to this slave while the bus is ready
  assign accept  = hsel && hready &&
                   ((htrans == htrans_nonseq) || (htrans == htrans_seq));
  assign size_ok = (hsize == hsize_word);

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state    <= st_okay;
      dp_valid <= 1'b0;
    end else begin
      // Only a word access reaches the register bank
      dp_valid <= accept && size_ok;
      case (state)
        // First error cycle always moves on to the second
        st_err_wait: state <= st_err_last;
        default:     state <= (accept && !size_ok) ? st_err_wait : st_okay;
      endcase
    end
  end

  // Address phase payload
  always_ff @(posedge hclk) begin
    if (accept) begin
      dp_idx   <= reg_index(haddr);
      dp_write <= hwrite;
    end
  end

  ////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////
  assign reg_bus.valid = dp_valid;
  assign reg_bus.write = dp_write;
  assign reg_bus.idx   = dp_idx;
  // Write data arrives during the data phase
  assign reg_bus.wdata = hwdata;

  assign hrdata    = (dp_valid && !dp_write) ? reg_bus.rdata : '0;
  // Stall only in the first error cycle
  assign hreadyout = (state != st_err_wait);
  assign hresp     = (state == st_okay) ? hresp_okay : hresp_error;

  // The bus sees a register access complete in its own data phase
  a_valid_ready : assert property (@(posedge hclk) disable iff (!rst_n)
    reg_bus.valid |-> hready);

endmodule

`default_nettype wire

// File: source/timer_regs.sv
// Timer register bank
// Control, prescaler, interrupt enable and compare registers, the read
// multiplexer for the register map and the registered interrupt output

`timescale 1ns/1ps
`default_nettype none

module timer_regs
  import timer_pkg::*;
(
  input  wire logic                              hclk,
  input  wire logic                              rst_n,
  input  wire logic [hdata_size-1:0]             mtime,
  input  wire logic [timers-1:0]                 ipend,
  timer_reg_if.regs                              reg_bus,
  output logic                                   enable,
  output logic      [hdata_size-1:0]             prescale,
  output logic                                   mtime_load,
  output logic      [hdata_size-1:0]             mtime_wdata,
  output logic      [timers-1:0][hdata_size-1:0] timecmp,
  output logic                                   tint
);

  logic              wr_en;
  logic [timers-1:0] ien;

  // Write strobe for the addressed register
  assign wr_en = reg_bus.valid && reg_bus.write;

  ////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      enable   <= 1'b0;
      prescale <= '0;
      ien      <= '0;
      timecmp  <= {timers{cmp_reset}};
    end else if (wr_en) begin
      case (reg_bus.idx)
        // Bit 0 is the only control bit
        reg_index(reg_ctrl):     enable   <= reg_bus.wdata[0];
        reg_index(reg_prescale): prescale <= reg_bus.wdata;
        reg_index(reg_ien):      ien      <= reg_bus.wdata[timers-1:0];
        default: ;
      endcase
      // Compare n sits one word above compare n-1
      for (int n = 0; n < timers; n++) begin
        if (reg_bus.idx == reg_index(reg_timecmp_base) + reg_idx_t'(n)) begin
          timecmp[n] <= reg_bus.wdata;
        end
      end
    end
  end

  // The counter itself lives in the core, a write becomes a load strobe
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      mtime_load <= 1'b0;
    end else begin
      mtime_load <= wr_en && (reg_bus.idx == reg_index(reg_mtime));
    end
  end

  // Load value, taken along with the strobe
  always_ff @(posedge hclk) begin
    mtime_wdata <= reg_bus.wdata;
  end

  ////////////////////////////////////////////////////////////
  // Read multiplexer
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Unmapped words read as zero
    reg_bus.rdata = '0;
    case (reg_bus.idx)
      reg_index(reg_ctrl):     reg_bus.rdata = hdata_size'(enable);
      reg_index(reg_prescale): reg_bus.rdata = prescale;
      reg_index(reg_mtime):    reg_bus.rdata = mtime;
      reg_index(reg_ien):      reg_bus.rdata = hdata_size'(ien);
      // Pending flags come straight from the comparators
      reg_index(reg_ipend):    reg_bus.rdata = hdata_size'(ipend);
      default: ;
    endcase
    for (int n = 0; n < timers; n++) begin
      if (reg_bus.idx == reg_index(reg_timecmp_base) + reg_idx_t'(n)) begin
        reg_bus.rdata = timecmp[n];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Interrupt
  ////////////////////////////////////////////////////////////

  // One clock behind the masked pending flags
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      tint <= 1'b0;
    end else begin
      tint <= |(ipend & ien);
    end
  end

  // Each bus write produces a single load pulse
  a_load_pulse : assert property (@(posedge hclk) disable iff (!rst_n)
    mtime_load |=> !mtime_load);

endmodule

`default_nettype wire

// File: source/timer_core.sv
// Timer core
// Prescaled free-running time counter and one comparator per channel
// producing the pending flags

`timescale 1ns/1ps
`default_nettype none

module timer_core
  import timer_pkg::*;
(
  input  wire logic                              hclk,
  input  wire logic                              rst_n,
  input  wire logic                              enable,
  input  wire logic [hdata_size-1:0]             prescale,
  input  wire logic                              mtime_load,
  input  wire logic [hdata_size-1:0]             mtime_wdata,
  input  wire logic [timers-1:0][hdata_size-1:0] timecmp,
  output logic      [hdata_size-1:0]             mtime,
  output logic      [timers-1:0]                 ipend
);

  logic [hdata_size-1:0] presc_cnt;
  logic                  tick;

  ////////////////////////////////////////////////////////////
  // Prescaler
  ////////////////////////////////////////////////////////////

  // A smaller prescale written mid-count still ends the period
  assign tick = enable && (presc_cnt >= prescale);

  always_ff @(posedge hclk) begin
    if (!rst_n || !enable || tick) begin
      presc_cnt <= '0;
    end else begin
      presc_cnt <= presc_cnt + 1'b1;
    end
  end

  // Time counter, a bus load wins over the tick
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      mtime <= '0;
    end else if (mtime_load) begin
      mtime <= mtime_wdata;
    end else if (tick) begin
      mtime <= mtime + 1'b1;
    end
  end

  // Pending while time has reached the compare value
  always_comb begin
    for (int n = 0; n < timers; n++) begin
      ipend[n] = (mtime >= timecmp[n]);
    end
  end

  // Time only moves when counting or loaded
  a_mtime_hold : assert property (@(posedge hclk) disable iff (!rst_n)
    (!enable && !mtime_load) |=> $stable(mtime));

endmodule

`default_nettype wire

// File: source/peripheral_timer_tl.sv
// AHB-Lite timer peripheral, top level
// Bus slave, register bank and timer core behind plain AHB-Lite ports

`timescale 1ns/1ps
`default_nettype none

module peripheral_timer_tl
  import timer_pkg::*;
(
  input  wire logic                  hclk,
  input  wire logic                  rst_n,
  // AHB-Lite slave port
  input  wire logic                  hsel,
  input  wire logic [haddr_size-1:0] haddr,
  input  wire logic [hdata_size-1:0] hwdata,
  output wire logic [hdata_size-1:0] hrdata,
  input  wire logic                  hwrite,
  input  wire logic [2:0]            hsize,
  // Burst, protection and lock carry no meaning for this slave
  input  wire logic [2:0]            hburst,
  input  wire logic [3:0]            hprot,
  input  wire logic [1:0]            htrans,
  input  wire logic                  hmastlock,
  input  wire logic                  hready,
  output wire logic                  hreadyout,
  output wire logic                  hresp,
  // Timer interrupt
  output wire logic                  tint
);

  // Configuration towards the core
  logic                              enable;
  logic [hdata_size-1:0]             prescale;
  logic                              mtime_load;
  logic [hdata_size-1:0]             mtime_wdata;
  logic [timers-1:0][hdata_size-1:0] timecmp;
  // Status back from the core
  logic [hdata_size-1:0]             mtime;
  logic [timers-1:0]                 ipend;

  timer_reg_if reg_bus ();

  timer_ahb_slave u_ahb_slave (
    .hclk, .rst_n, .hsel, .haddr, .hwdata, .hwrite, .hsize, .htrans, .hready,
    .hrdata, .hreadyout, .hresp,
    .reg_bus (reg_bus.bus)
  );

  timer_regs u_regs (
    .hclk, .rst_n, .mtime, .ipend,
    .reg_bus (reg_bus.regs),
    .enable, .prescale, .mtime_load, .mtime_wdata, .timecmp, .tint
  );

  timer_core u_core (
    .hclk, .rst_n, .enable, .prescale, .mtime_load, .mtime_wdata, .timecmp,
    .mtime, .ipend
  );

endmodule

`default_nettype wire

// File: verif/peripheral_timer_tb.sv
// Directed testbench of the AHB-Lite timer peripheral
// AHB master tasks, a shadow model of the register map and checks of reset
// values, read-back, counting rate, compare, masking and size errors

`timescale 1ns/1ps
`default_nettype none

module peripheral_timer_tb
  import ahb_lite_pkg::*;
  import timer_pkg::*;
();

  // Timeout at twice the length of the tests
  localparam int test_cycles    = 1500;
  localparam int timeout_cycles = 2 * test_cycles;

  logic                  hclk;
  logic                  rst_n;
  logic                  hsel;
  logic [haddr_size-1:0] haddr;
  logic [hdata_size-1:0] hwdata;
  logic [hdata_size-1:0] hrdata;
  logic                  hwrite;
  logic [2:0]            hsize;
  logic [1:0]            htrans;
  logic                  hready;
  logic                  hreadyout;
  logic                  hresp;
  logic                  tint;

  int cycle  = 0;
  int checks = 0;
  int errors = 0;
  // Expected contents of every register word by word index
  logic [hdata_size-1:0] model [32];

  // Only one slave drives the bus ready
  assign hready = hreadyout;

  peripheral_timer_tl uut (
    .hclk, .rst_n, .hsel, .haddr, .hwdata, .hrdata, .hwrite, .hsize,
    .hburst (3'b000), .hprot (4'b0000), .htrans, .hmastlock (1'b0),
    .hready, .hreadyout, .hresp, .tint
  );

  initial begin
    hclk = 1'b0;
    forever #2 hclk = ~hclk;
  end

  always @(posedge hclk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks and register map model
  ////////////////////////////////////////////////////////////
  task automatic check_equal(input string name, input logic [hdata_size-1:0] got,
                             input logic [hdata_size-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  function automatic logic [haddr_size-1:0] cmp_addr(input int n);
    return reg_timecmp_base + haddr_size'(4 * n);
  endfunction

  // Reset state where unmapped and read-only words hold zero
  task automatic init_model();
    for (int i = 0; i < 32; i++)
      model[i] = '0;
    for (int n = 0; n < timers; n++)
      model[cmp_addr(n) >> 2] = '1;
  endtask

  // Applies the field widths of each writable register
  task automatic update_model(input logic [haddr_size-1:0] addr,
                              input logic [hdata_size-1:0] data);
    case (addr)
      reg_ctrl:     model[addr >> 2] = {31'b0, data[0]};
      reg_prescale: model[addr >> 2] = data;
      reg_ien:      model[addr >> 2] = data & hdata_size'((1 << timers) - 1);
      default: begin
        for (int n = 0; n < timers; n++)
          if (addr == cmp_addr(n))
            model[addr >> 2] = data;
      end
    endcase
  endtask

  // Pending flags that a given time should give
  function automatic logic [hdata_size-1:0] expected_ipend(input logic [hdata_size-1:0] t);
    logic [hdata_size-1:0] e;
    e = '0;
    for (int n = 0; n < timers; n++)
      e[n] = (t >= model[cmp_addr(n) >> 2]);
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // AHB master tasks entered and left 1 ns after a rising edge
  ////////////////////////////////////////////////////////////
  task automatic address_phase(input logic [haddr_size-1:0] addr, input logic wr,
                               input logic [2:0] size);
    hsel   = 1'b1;
    haddr  = addr;
    hwrite = wr;
    hsize  = size;
    htrans = htrans_nonseq;
    @(posedge hclk);
    #1;
    hsel   = 1'b0;
    htrans = htrans_idle;
  endtask

  task automatic ahb_write(input logic [haddr_size-1:0] addr,
                           input logic [hdata_size-1:0] data);
    address_phase(addr, 1'b1, hsize_word);
    hwdata = data;
    check_equal("hresp on write", hdata_size'(hresp), hdata_size'(hresp_okay));
    check_equal("hreadyout on write", hdata_size'(hreadyout), 1);
    @(posedge hclk);
    #1;
    update_model(addr, data);
  endtask

  task automatic ahb_read(input logic [haddr_size-1:0] addr,
                          output logic [hdata_size-1:0] data);
    address_phase(addr, 1'b0, hsize_word);
    data = hrdata;
    check_equal("hresp on read", hdata_size'(hresp), hdata_size'(hresp_okay));
    check_equal("hreadyout on read", hdata_size'(hreadyout), 1);
    @(posedge hclk);
    #1;
  endtask

  // Non-word write that returns the response and the stalled cycle count
  task automatic ahb_access_size(input logic [haddr_size-1:0] addr, input logic [2:0] size,
                                 input logic [hdata_size-1:0] data, output logic resp,
                                 output int low_cycles);
    address_phase(addr, 1'b1, size);
    hwdata     = data;
    resp       = hresp;
    low_cycles = 0;
    while (!hreadyout && low_cycles < 4) begin
      low_cycles++;
      @(posedge hclk);
      #1;
    end
    if (hresp !== resp)
      report_error("hresp changed between the two error cycles");
    @(posedge hclk);
    #1;
  endtask

  task automatic wait_tint(input logic level, input int limit);
    int n;
    n = 0;
    while (tint !== level && n < limit) begin
      @(posedge hclk);
      #1;
      n++;
    end
    if (tint !== level)
      report_error($sformatf("tint did not go to %0d within %0d cycles", level, limit));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic read_reset_values();
    logic [hdata_size-1:0] got;
    // Whole index space with mapped and unmapped words alike
    for (int a = 0; a < 128; a += 4) begin
      ahb_read(haddr_size'(a), got);
      check_equal($sformatf("reset word 0x%02h", a), got, model[a >> 2]);
    end
    check_equal("tint after reset", hdata_size'(tint), 0);
  endtask

  task automatic register_readback();
    logic [hdata_size-1:0] got;
    ahb_write(reg_prescale, $urandom());
    ahb_write(reg_ien, $urandom());
    for (int n = 0; n < timers; n++)
      ahb_write(cmp_addr(n), $urandom());
    ahb_read(reg_prescale, got);
    check_equal("prescale", got, model[reg_prescale >> 2]);
    ahb_read(reg_ien, got);
    check_equal("ien", got, model[reg_ien >> 2]);
    for (int n = 0; n < timers; n++) begin
      ahb_read(cmp_addr(n), got);
      check_equal($sformatf("timecmp%0d", n), got, model[cmp_addr(n) >> 2]);
    end
    // Read-only flags follow the comparators while time is still zero
    ahb_write(reg_ipend, '1);
    ahb_read(reg_ipend, got);
    check_equal("ipend after write", got, expected_ipend('0));
    ahb_write(reg_ien, '0);
    for (int n = 0; n < timers; n++)
      ahb_write(cmp_addr(n), cmp_reset);
  endtask

  task automatic counting_rate();
    logic [hdata_size-1:0] load;
    logic [hdata_size-1:0] exp;
    logic [hdata_size-1:0] got;
    logic [hdata_size-1:0] later;
    int                    start;
    load = $urandom() & 32'h00ff_ffff;
    ahb_write(reg_mtime, load);
    ahb_write(reg_prescale, 3);
    ahb_write(reg_ctrl, 1);
    start = cycle;
    repeat (40) @(posedge hclk);
    #1;
    ahb_write(reg_ctrl, 0);
    // One increment per four clocks while enabled
    exp = load + (cycle - start) / 4;
    ahb_read(reg_mtime, got);
    checks++;
    if (got + 1 < exp || got > exp + 1) begin
      errors++;
      $display("Fail at %0t ns: mtime is 0x%08h, expected 0x%08h +/- 1", $time, got, exp);
    end
    repeat (20) @(posedge hclk);
    #1;
    ahb_read(reg_mtime, later);
    check_equal("mtime while disabled", later, got);
  endtask

  task automatic compare_interrupt();
    logic [hdata_size-1:0] now;
    logic [hdata_size-1:0] got;
    ahb_read(reg_mtime, now);
    ahb_write(cmp_addr(1), now + 5);
    ahb_write(reg_ien, 32'h2);
    ahb_write(reg_ctrl, 1);
    // Five ticks of four clocks plus the register stage
    wait_tint(1'b1, 60);
    ahb_read(reg_ipend, got);
    check_equal("ipend bit 1 at compare", hdata_size'(got[1]), 1);
    ahb_write(cmp_addr(1), cmp_reset);
    ahb_read(reg_ipend, got);
    check_equal("ipend bit 1 after clear", hdata_size'(got[1]), 0);
    check_equal("tint after clear", hdata_size'(tint), 0);
    ahb_write(reg_ctrl, 0);
    ahb_write(reg_ien, '0);
  endtask

  task automatic interrupt_masking();
    logic [hdata_size-1:0] got;
    // Compare at zero keeps channel 2 pending at any time
    ahb_write(cmp_addr(2), '0);
    ahb_read(reg_ipend, got);
    check_equal("ipend bit 2", hdata_size'(got[2]), 1);
    repeat (20) begin
      @(posedge hclk);
      #1;
      check_equal("tint while masked", hdata_size'(tint), 0);
    end
    ahb_write(reg_ien, 32'h4);
    wait_tint(1'b1, 4);
    ahb_write(reg_ien, '0);
    ahb_write(cmp_addr(2), cmp_reset);
  endtask

  task automatic size_error();
    logic                  resp;
    int                    low;
    logic [hdata_size-1:0] got;
    ahb_access_size(reg_prescale, 3'b001, 32'h0000_abcd, resp, low);
    check_equal("hresp on halfword write", hdata_size'(resp), hdata_size'(hresp_error));
    check_equal("hreadyout low cycles", low, 1);
    // Word read right after must get OKAY and the old value
    ahb_read(reg_prescale, got);
    check_equal("prescale after error", got, model[reg_prescale >> 2]);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] seed_draw;
    rst_n  = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    hwdata = '0;
    hwrite = 1'b0;
    hsize  = hsize_word;
    htrans = htrans_idle;
    seed_draw = $urandom(32'h0fe6_13a0);
    init_model();
    repeat (10) @(posedge hclk);
    #1;
    rst_n = 1'b1;
    read_reset_values();
    register_readback();
    counting_rate();
    compare_interrupt();
    interrupt_masking();
    size_error();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
source/ahb_lite_pkg.sv
source/timer_pkg.sv
source/timer_reg_if.sv
source/timer_ahb_slave.sv
source/timer_regs.sv
source/timer_core.sv
source/peripheral_timer_tl.sv
verif/peripheral_timer_tb.sv

// File: Bender.yml
package:
  name: peripheral_timer

sources:
  - source/ahb_lite_pkg.sv
  - source/timer_pkg.sv
  - source/timer_reg_if.sv
  - source/timer_ahb_slave.sv
  - source/timer_regs.sv
  - source/timer_core.sv
  - source/peripheral_timer_tl.sv
  - target: test
    files:
      - verif/peripheral_timer_tb.sv
